//--- hw/bus_share.sv
`timescale 1ns/1ps
`include "mf_macros.svh"

module bus_share (
	input logic CLK,
	input logic rstf,
	input logic cyc_i,
	input logic stb_i,
	input logic [`MF_NUM_FUNC-1:0] req_i,
	input logic [`MF_NUM_FUNC-1:0] ack_i,
	input logic [`MF_DATA_W-1:0] f0_dat_i,
	input logic [`MF_DATA_W-1:0] f1_dat_i,
	input logic [`MF_DATA_W-1:0] f2_dat_i,
	output logic [`MF_NUM_FUNC-1:0] gnt_o,
	output logic [`MF_DATA_W-1:0] dat_o,
	output logic ack_o,
	output logic err_o
);
	import mf_pkg::*;

	localparam int RST_STAGES = 4;
	localparam int CNT_W = $clog2(`MF_NUM_FUNC + 1);

	logic [RST_STAGES-1:0] rst_sync;
	logic ready;
	share_state_t state;
	logic [CNT_W-1:0] req_cnt;
	logic [`MF_NUM_FUNC-1:0] pri_gnt;
	logic bus_free;
	logic bad_sel;

	// ##################################################
	// reset release.
	// ones shift in after rstf rises; the bus opens when the last stage is set.
	always_ff @(posedge CLK or negedge rstf)
	begin
		if (!rstf)
			rst_sync <= '0;
		else
			rst_sync <= {rst_sync[RST_STAGES-2:0], 1'b1};
	end

	assign ready = rst_sync[RST_STAGES-1];

	// ##################################################
	// request count and fixed-priority grant.
	always_comb
	begin
		req_cnt = '0;
		for (int i = 0; i < `MF_NUM_FUNC; i++)
			req_cnt = req_cnt + CNT_W'(req_i[i]);
	end

	// walk down so the lowest index wins.
	always_comb
	begin
		pri_gnt = '0;
		for (int i = `MF_NUM_FUNC - 1; i >= 0; i--)
		begin
			if (req_i[i])
			begin
				pri_gnt = '0;
				pri_gnt[i] = 1'b1;
			end
		end
	end

	assign bus_free = ready && (state == SS_IDLE) && (ack_i == '0);
	assign gnt_o = (bus_free && req_cnt == CNT_W'(1)) ? pri_gnt : '0;

	// zero or several selected functions end the cycle with err.
	assign bad_sel = bus_free && cyc_i && stb_i && (req_cnt != CNT_W'(1));

	always_ff @(posedge CLK or negedge rstf)
	begin
		if (!rstf)
			state <= SS_IDLE;
		else
		begin
			case (state)
				SS_IDLE:
				begin
					if (bad_sel)
						state <= SS_ERR;
				end
				default: state <= SS_IDLE;
			endcase
		end
	end

	// ##################################################
	// read data and acknowledge merge.
	always_comb
	begin
		if (ack_i[0])
			dat_o = f0_dat_i;
		else if (ack_i[1])
			dat_o = f1_dat_i;
		else if (ack_i[2])
			dat_o = f2_dat_i;
		else
			dat_o = '0;
	end

	assign ack_o = |ack_i;
	assign err_o = (state == SS_ERR); // one cycle, never with ack.

endmodule

//--- hw/func_regs.sv
`timescale 1ns/1ps
`include "mf_macros.svh"

module func_regs #(
	parameter int FUNC_ID = 0
) (
	input logic CLK,
	input logic rstf,
	input logic cyc_i,
	input logic stb_i,
	input logic we_i,
	input logic [`MF_ADR_W-1:0] adr_i,
	input logic [`MF_SEL_W-1:0] sel_i,
	input logic [`MF_DATA_W-1:0] dat_i,
	input logic gnt_i,
	output logic req_o,
	output logic ack_o,
	output logic [`MF_DATA_W-1:0] dat_o,
	output logic int_o
);
	import mf_pkg::*;

	func_state_t state;
	reg_sel_t reg_sel;
	logic sel_hit;
	logic [`MF_DATA_W-1:0] data0;
	logic [`MF_DATA_W-1:0] data1;
	logic [`MF_DATA_W-1:0] ctrl;
	logic [`MF_DATA_W-1:0] id_val;
	logic [`MF_DATA_W-1:0] rd_val;

	// replaces the bytes of old_val that sel enables.
	function automatic logic [`MF_DATA_W-1:0] byte_merge(
		input logic [`MF_DATA_W-1:0] old_val,
		input logic [`MF_DATA_W-1:0] new_val,
		input logic [`MF_SEL_W-1:0] sel
	);
		logic [`MF_DATA_W-1:0] res;
		res = old_val;
		for (int b = 0; b < `MF_SEL_W; b++)
		begin
			if (sel[b])
				res[b*8 +: 8] = new_val[b*8 +: 8];
		end
		return res;
	endfunction

	// ##################################################
	// decode and request.
	assign sel_hit = adr_i[`MF_IDSEL_LSB + FUNC_ID];
	assign reg_sel = reg_sel_t'(adr_i[3:2]);
	assign req_o = (state == FS_IDLE) && cyc_i && stb_i && sel_hit;

	assign id_val = {`MF_ID_SIG, 8'h00, 8'(FUNC_ID)};

	always_comb
	begin
		rd_val = id_val;
		case (reg_sel)
			REG_DATA0: rd_val = data0;
			REG_DATA1: rd_val = data1;
			REG_CTRL: rd_val = ctrl;
			default: rd_val = id_val;
		endcase
	end

	// ##################################################
	// access on grant.
	always_ff @(posedge CLK or negedge rstf)
	begin
		if (!rstf)
		begin
			state <= FS_IDLE;
			data0 <= '0;
			data1 <= '0;
			ctrl <= '0;
		end
		else
		begin
			case (state)
				FS_IDLE:
				begin
					if (gnt_i)
					begin
						state <= FS_ACK;
						if (we_i)
						begin
							case (reg_sel)
								REG_DATA0: data0 <= byte_merge(data0, dat_i, sel_i);
								REG_DATA1: data1 <= byte_merge(data1, dat_i, sel_i);
								REG_CTRL: ctrl <= byte_merge(ctrl, dat_i, sel_i);
								default: ; // the ID register is read only.
							endcase
						end
					end
				end
				default: state <= FS_IDLE; // ack lasts one cycle.
			endcase
		end
	end

	// a granted read captures the selected register.
	always_ff @(posedge CLK)
	begin
		if (gnt_i && !we_i)
			dat_o <= rd_val;
	end

	assign ack_o = (state == FS_ACK);
	assign int_o = ctrl[0]; // level interrupt from the control register.

endmodule

//--- hw/mf_macros.svh
`ifndef MF_MACROS_SVH
`define MF_MACROS_SVH

// ##################################################
// bus widths.
`define MF_ADR_W 32
`define MF_DATA_W 32
`define MF_SEL_W 4

// ##################################################
// function layout on the host bus.
`define MF_NUM_FUNC 3
// function n answers when address bit MF_IDSEL_LSB + n is set.
`define MF_IDSEL_LSB 24

// upper half of every ID register.
`define MF_ID_SIG 16'hC35A

`endif

//--- hw/mf_pkg.sv
package mf_pkg;

	// per-function access state.
	typedef enum logic
	{
		FS_IDLE,
		FS_ACK
	} func_state_t;

	// error terminator in the bus sharing block.
	typedef enum logic
	{
		SS_IDLE,
		SS_ERR
	} share_state_t;

	// register select, taken from address bits 3 and 2.
	typedef enum logic [1:0]
	{
		REG_DATA0 = 2'd0,
		REG_DATA1 = 2'd1,
		REG_CTRL = 2'd2,
		REG_ID = 2'd3
	} reg_sel_t;

endpackage

//--- hw/multi_func_top.sv
`timescale 1ns/1ps
`include "mf_macros.svh"

module multi_func_top (
	input logic CLK,
	input logic rstf,
	input logic wb_cyc_i,
	input logic wb_stb_i,
	input logic wb_we_i,
	input logic [`MF_ADR_W-1:0] wb_adr_i,
	input logic [`MF_SEL_W-1:0] wb_sel_i,
	input logic [`MF_DATA_W-1:0] wb_dat_i,
	output logic [`MF_DATA_W-1:0] wb_dat_o,
	output logic wb_ack_o,
	output logic wb_err_o,
	output logic [`MF_NUM_FUNC-1:0] int_o
);

	logic [`MF_NUM_FUNC-1:0] req;
	logic [`MF_NUM_FUNC-1:0] gnt;
	logic [`MF_NUM_FUNC-1:0] ack;
	logic [`MF_DATA_W-1:0] f0_dat;
	logic [`MF_DATA_W-1:0] f1_dat;
	logic [`MF_DATA_W-1:0] f2_dat;

	// ##################################################
	// the three functions all see the same host bus.
	func_regs #(.FUNC_ID(0)) u_func0 (
		.CLK(CLK),
		.rstf(rstf),
		.cyc_i(wb_cyc_i),
		.stb_i(wb_stb_i),
		.we_i(wb_we_i),
		.adr_i(wb_adr_i),
		.sel_i(wb_sel_i),
		.dat_i(wb_dat_i),
		.gnt_i(gnt[0]),
		.req_o(req[0]),
		.ack_o(ack[0]),
		.dat_o(f0_dat),
		.int_o(int_o[0])
	);

	func_regs #(.FUNC_ID(1)) u_func1 (
		.CLK(CLK),
		.rstf(rstf),
		.cyc_i(wb_cyc_i),
		.stb_i(wb_stb_i),
		.we_i(wb_we_i),
		.adr_i(wb_adr_i),
		.sel_i(wb_sel_i),
		.dat_i(wb_dat_i),
		.gnt_i(gnt[1]),
		.req_o(req[1]),
		.ack_o(ack[1]),
		.dat_o(f1_dat),
		.int_o(int_o[1])
	);

	func_regs #(.FUNC_ID(2)) u_func2 (
		.CLK(CLK),
		.rstf(rstf),
		.cyc_i(wb_cyc_i),
		.stb_i(wb_stb_i),
		.we_i(wb_we_i),
		.adr_i(wb_adr_i),
		.sel_i(wb_sel_i),
		.dat_i(wb_dat_i),
		.gnt_i(gnt[2]),
		.req_o(req[2]),
		.ack_o(ack[2]),
		.dat_o(f2_dat),
		.int_o(int_o[2])
	);

	// ##################################################
	// grant, merge and error termination.
	bus_share u_share (
		.CLK(CLK),
		.rstf(rstf),
		.cyc_i(wb_cyc_i),
		.stb_i(wb_stb_i),
		.req_i(req),
		.ack_i(ack),
		.f0_dat_i(f0_dat),
		.f1_dat_i(f1_dat),
		.f2_dat_i(f2_dat),
		.gnt_o(gnt),
		.dat_o(wb_dat_o),
		.ack_o(wb_ack_o),
		.err_o(wb_err_o)
	);

endmodule

//--- run_sim.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -f sim.f --top-module tb_multi_func -Mdir obj_dir; then
	echo "verilator compile failed"
	exit 1
fi

./obj_dir/Vtb_multi_func > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "TEST PASS" "$LOG"; then
	exit 0
fi

echo "pass message not found in $LOG"
exit 1

//--- sim.f
+incdir+hw
hw/mf_pkg.sv
hw/func_regs.sv
hw/bus_share.sv
hw/multi_func_top.sv
tb/mf_assertions.sv
tb/tb_multi_func.sv

//--- tb/mf_assertions.sv
`timescale 1ns/1ps
`include "mf_macros.svh"

module mf_assertions (
	input logic CLK,
	input logic rstf,
	input logic cyc_i,
	input logic stb_i,
	input logic [`MF_NUM_FUNC-1:0] gnt_i,
	input logic ack_i,
	input logic err_i
);

	// ##################################################
	// host port protocol.
	ack_err_excl: assert property (@(posedge CLK) disable iff (!rstf) !(ack_i && err_i))
		else $error("ack and err are high together");

	// an ack is only given while the master still holds its request.
	ack_in_cycle: assert property (@(posedge CLK) disable iff (!rstf)
		ack_i |-> cyc_i && stb_i)
		else $error("ack without an active cyc and stb");

	gnt_onehot: assert property (@(posedge CLK) disable iff (!rstf) $onehot0(gnt_i))
		else $error("more than one grant is high");

endmodule

bind bus_share mf_assertions u_assert (
	.CLK(CLK),
	.rstf(rstf),
	.cyc_i(cyc_i),
	.stb_i(stb_i),
	.gnt_i(gnt_o),
	.ack_i(ack_o),
	.err_i(err_o)
);

//--- tb/mf_tests.txt
# op addr sel wdata term rdata, all numbers in hex
# op is W or R, term is A for ack or E for err, rdata is checked on reads
W 00000000 f 12345678 E 00000000
W 03000004 f 12345678 E 00000000
R 01000000 f 00000000 A 00000000
R 01000004 f 00000000 A 00000000
R 01000008 f 00000000 A 00000000
R 02000000 f 00000000 A 00000000
R 02000004 f 00000000 A 00000000
R 02000008 f 00000000 A 00000000
R 04000000 f 00000000 A 00000000
R 04000004 f 00000000 A 00000000
R 04000008 f 00000000 A 00000000
W 01000000 3 deadbeef A 00000000
R 01000000 f 00000000 A 0000beef
R 0200000c f 00000000 A c35a0001
W 0400000c f ffffffff A 00000000
R 0400000c f 00000000 A c35a0002
W 02000008 1 00000001 A 00000000
W 02000008 1 00000000 A 00000000

//--- tb/tb_multi_func.sv
`timescale 1ns/1ps
`include "mf_macros.svh"

module tb_multi_func;
	import mf_pkg::*;

	localparam int ACK_TIMEOUT = 20;

	logic CLK;
	logic rstf;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [`MF_ADR_W-1:0] wb_adr;
	logic [`MF_SEL_W-1:0] wb_sel;
	logic [`MF_DATA_W-1:0] wb_wdat;
	logic [`MF_DATA_W-1:0] wb_rdat;
	logic wb_ack;
	logic wb_err;
	logic [`MF_NUM_FUNC-1:0] int_vec;

	logic [`MF_NUM_FUNC-1:0] int_model; // expected int_o as the CTRL writes set it.
	logic timed_out;
	logic run_done;
	int data_err;
	int term_err;
	int int_err;
	int timeouts;
	int file_err;
	int vec_cnt;

	multi_func_top i_dut (
		.CLK(CLK),
		.rstf(rstf),
		.wb_cyc_i(wb_cyc),
		.wb_stb_i(wb_stb),
		.wb_we_i(wb_we),
		.wb_adr_i(wb_adr),
		.wb_sel_i(wb_sel),
		.wb_dat_i(wb_wdat),
		.wb_dat_o(wb_rdat),
		.wb_ack_o(wb_ack),
		.wb_err_o(wb_err),
		.int_o(int_vec)
	);

	initial
	begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	// ##################################################
	// one classic cycle that is held until ack or err.
	task automatic bus_access(
		input logic write,
		input logic [`MF_ADR_W-1:0] adr,
		input logic [`MF_SEL_W-1:0] sel,
		input logic [`MF_DATA_W-1:0] wdat,
		output logic got_ack,
		output logic got_err,
		output logic [`MF_DATA_W-1:0] rdat
	);
		got_ack = 1'b0;
		got_err = 1'b0;
		rdat = '0;
		timed_out = 1'b1;
		@(negedge CLK);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = write;
		wb_adr = adr;
		wb_sel = sel;
		wb_wdat = wdat;
		for (int c = 0; c < ACK_TIMEOUT; c++)
		begin
			@(negedge CLK);
			if (wb_ack || wb_err)
			begin
				got_ack = wb_ack;
				got_err = wb_err;
				rdat = wb_rdat;
				timed_out = 1'b0;
				break;
			end
		end
		// the master keeps its strobe through the terminating edge.
		if (!timed_out)
			@(negedge CLK);
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic run_vector(
		input logic [7:0] op,
		input logic [`MF_ADR_W-1:0] adr,
		input logic [`MF_SEL_W-1:0] sel,
		input logic [`MF_DATA_W-1:0] wdat,
		input logic [7:0] term,
		input logic [`MF_DATA_W-1:0] exp_dat
	);
		logic got_ack;
		logic got_err;
		logic [`MF_DATA_W-1:0] rdat;
		bus_access(op == "W", adr, sel, wdat, got_ack, got_err, rdat);
		if (timed_out)
		begin
			$display("timeout: access to %h got neither ack nor err in %0d cycles", adr,
				ACK_TIMEOUT);
			timeouts++;
		end
		else
		begin
			if (got_ack !== (term == "A") || got_err !== (term == "E"))
			begin
				$display("[FAIL] %0t: %h ended with ack %b err %b, expected %s", $time, adr,
					got_ack, got_err, term);
				term_err++;
			end
			if (op == "R" && term == "A" && got_ack && rdat !== exp_dat)
			begin
				$display("[FAIL] %0t: read %h gave %h, expected %h", $time, adr, rdat, exp_dat);
				data_err++;
			end
			// bit 0 of a CTRL register is the level interrupt of its function.
			if (op == "W" && term == "A" && reg_sel_t'(adr[3:2]) == REG_CTRL && sel[0])
			begin
				for (int f = 0; f < `MF_NUM_FUNC; f++)
				begin
					if (adr[`MF_IDSEL_LSB + f])
						int_model[f] = wdat[0];
				end
			end
			if (int_vec !== int_model)
			begin
				$display("[FAIL] %0t: int_o is %b, expected %b", $time, int_vec, int_model);
				int_err++;
			end
		end
	endtask

	task automatic finish_run;
		int total;
		total = data_err + term_err + int_err + timeouts + file_err;
		$display("errors: data %0d, termination %0d, interrupt %0d, timeout %0d, file %0d",
			data_err, term_err, int_err, timeouts, file_err);
		run_done = 1'b1;
		if (total == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	endtask

	// ##################################################
	// reset and then one access per line of the test file.
	initial
	begin
		int fd;
		int n;
		string line;
		logic [7:0] op;
		logic [7:0] term;
		logic [`MF_ADR_W-1:0] adr_v;
		logic [`MF_SEL_W-1:0] sel_v;
		logic [`MF_DATA_W-1:0] wdat_v;
		logic [`MF_DATA_W-1:0] exp_v;
		rstf = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_sel = '0;
		wb_wdat = '0;
		int_model = '0;
		timed_out = 1'b0;
		run_done = 1'b0;
		data_err = 0;
		term_err = 0;
		int_err = 0;
		timeouts = 0;
		file_err = 0;
		vec_cnt = 0;
		repeat (4) @(posedge CLK);
		@(negedge CLK);
		rstf = 1'b1;
		if (int_vec !== '0)
		begin
			$display("[FAIL] %0t: int_o is %b after reset", $time, int_vec);
			int_err++;
		end
		fd = $fopen("tb/mf_tests.txt", "r");
		if (fd == 0)
		begin
			$display("could not open tb/mf_tests.txt");
			file_err++;
		end
		else
		begin
			while (!timed_out && !$feof(fd))
			begin
				n = $fgets(line, fd);
				if (n > 0 && line[0] != "#")
				begin
					n = $sscanf(line, "%s %h %h %h %s %h", op, adr_v, sel_v, wdat_v, term, exp_v);
					if (n == 6)
					begin
						vec_cnt++;
						run_vector(op, adr_v, sel_v, wdat_v, term, exp_v);
					end
				end
			end
			$fclose(fd);
			if (vec_cnt == 0)
			begin
				$display("no test vectors found in tb/mf_tests.txt");
				file_err++;
			end
		end
		finish_run();
	end

	// a run stopped by a failed assertion ends here without the closing line.
	final
	begin
		if (!run_done)
			$display("TEST FAIL");
	end

endmodule
